//--- hdl/tomasulo_pkg.sv
`default_nettype none

package tomasulo_pkg;

    localparam int data_w     = 16;
    localparam int reg_w      = 4;
    localparam int num_regs   = 1 << reg_w;
    localparam int rob_w      = 3;
    localparam int rob_depth  = 8;
    localparam int rs_depth   = 3;
    localparam int rs_w       = 2;   // index into a station
    localparam int age_w      = 2;   // counts younger entries, at most rs_depth-1
    localparam int mul_cycles = 3;
    localparam int div_cycles = 5;
    localparam int cycle_w    = 3;
    localparam int opcode_w   = 4;

    typedef logic [cycle_w-1:0] cycle_t;

    typedef enum logic [opcode_w-1:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_mul = 4'd2,
        op_div = 4'd3,
        op_li  = 4'd4
    } opcode_t;

endpackage

`default_nettype wire

//--- hdl/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station (
    input  wire                                 clk1,
    input  wire                                 rst_n,
    input  wire                                 alloc,
    input  wire tomasulo_pkg::opcode_t          alloc_op,
    input  wire [tomasulo_pkg::rob_w-1:0]       alloc_tag,
    input  wire [tomasulo_pkg::data_w-1:0]      a_value,
    input  wire [tomasulo_pkg::rob_w-1:0]       a_tag,
    input  wire                                 a_ready,
    input  wire [tomasulo_pkg::data_w-1:0]      b_value,
    input  wire [tomasulo_pkg::rob_w-1:0]       b_tag,
    input  wire                                 b_ready,
    input  wire                                 unit_busy,
    input  wire                                 cdb_valid,
    input  wire [tomasulo_pkg::rob_w-1:0]       cdb_tag,
    input  wire [tomasulo_pkg::data_w-1:0]      cdb_value,
    output logic                                full,
    output logic                                disp_valid,
    output tomasulo_pkg::opcode_t               disp_op,
    output logic [tomasulo_pkg::data_w-1:0]     disp_a,
    output logic [tomasulo_pkg::data_w-1:0]     disp_b,
    output logic [tomasulo_pkg::rob_w-1:0]      disp_tag
);

    logic [tomasulo_pkg::rs_depth-1:0]  busy;
    logic [tomasulo_pkg::rs_depth-1:0]  a_rdy;
    logic [tomasulo_pkg::rs_depth-1:0]  b_rdy;
    logic [tomasulo_pkg::rs_depth-1:0]  older;
    logic [tomasulo_pkg::age_w-1:0]     age    [tomasulo_pkg::rs_depth];
    tomasulo_pkg::opcode_t              op     [tomasulo_pkg::rs_depth];
    logic [tomasulo_pkg::rob_w-1:0]     tag    [tomasulo_pkg::rs_depth];
    logic [tomasulo_pkg::data_w-1:0]    a_val  [tomasulo_pkg::rs_depth];
    logic [tomasulo_pkg::rob_w-1:0]     a_wait [tomasulo_pkg::rs_depth];
    logic [tomasulo_pkg::data_w-1:0]    b_val  [tomasulo_pkg::rs_depth];
    logic [tomasulo_pkg::rob_w-1:0]     b_wait [tomasulo_pkg::rs_depth];
    logic [tomasulo_pkg::rs_w-1:0]      free_idx;
    logic [tomasulo_pkg::rs_w-1:0]      sel_idx;
    logic                               sel_found;

    always_comb
    begin
        full     = 1'b1;
        free_idx = '0;
        for (int i = tomasulo_pkg::rs_depth - 1; i >= 0; i--)
        begin
            if (!busy[i])
            begin
                full     = 1'b0;
                free_idx = i[tomasulo_pkg::rs_w-1:0];   // lowest free slot wins
            end
        end
    end

    // the oldest entry is the one with the most younger entries behind it
    always_comb
    begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = 0; i < tomasulo_pkg::rs_depth; i++)
        begin
            if (busy[i] && a_rdy[i] && b_rdy[i] && (!sel_found || age[i] > age[sel_idx]))
            begin
                sel_found = 1'b1;
                sel_idx   = i[tomasulo_pkg::rs_w-1:0];
            end
        end
        for (int i = 0; i < tomasulo_pkg::rs_depth; i++)
            older[i] = disp_valid && busy[i] && age[i] > age[sel_idx];
    end

    assign disp_valid = sel_found && !unit_busy;
    assign disp_op    = op[sel_idx];
    assign disp_a     = a_val[sel_idx];
    assign disp_b     = b_val[sel_idx];
    assign disp_tag   = tag[sel_idx];

    always_ff @(posedge clk1 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy  <= '0;
            a_rdy <= '0;
            b_rdy <= '0;
            age   <= '{default: '0};
        end
        else
        begin
            for (int i = 0; i < tomasulo_pkg::rs_depth; i++)
            begin
                if (busy[i] && !a_rdy[i] && cdb_valid && cdb_tag == a_wait[i])
                    a_rdy[i] <= 1'b1;
                if (busy[i] && !b_rdy[i] && cdb_valid && cdb_tag == b_wait[i])
                    b_rdy[i] <= 1'b1;
                if (busy[i] && alloc && !older[i])
                    age[i] <= age[i] + 1;
                else if (busy[i] && !alloc && older[i])
                    age[i] <= age[i] - 1;
            end
            if (disp_valid)
                busy[sel_idx] <= 1'b0;
            if (alloc)
            begin
                busy[free_idx]  <= 1'b1;
                a_rdy[free_idx] <= a_ready;
                b_rdy[free_idx] <= b_ready;
                age[free_idx]   <= '0;
            end
        end
    end

    always_ff @(posedge clk1)
    begin
        for (int i = 0; i < tomasulo_pkg::rs_depth; i++)
        begin
            if (busy[i] && !a_rdy[i] && cdb_valid && cdb_tag == a_wait[i])
                a_val[i] <= cdb_value;
            if (busy[i] && !b_rdy[i] && cdb_valid && cdb_tag == b_wait[i])
                b_val[i] <= cdb_value;
        end
        if (alloc)
        begin
            op[free_idx]     <= alloc_op;
            tag[free_idx]    <= alloc_tag;
            a_val[free_idx]  <= a_value;
            a_wait[free_idx] <= a_tag;
            b_val[free_idx]  <= b_value;
            b_wait[free_idx] <= b_tag;
        end
    end

endmodule

`default_nettype wire

//--- hdl/add_exec.sv
`timescale 1ns/1ps
`default_nettype none

module add_exec (
    input  wire                                 clk1,
    input  wire                                 rst_n,
    input  wire                                 disp_valid,
    input  wire tomasulo_pkg::opcode_t          disp_op,
    input  wire [tomasulo_pkg::data_w-1:0]      disp_a,
    input  wire [tomasulo_pkg::data_w-1:0]      disp_b,
    input  wire [tomasulo_pkg::rob_w-1:0]       disp_tag,
    input  wire                                 mul_req,
    input  wire [tomasulo_pkg::rob_w-1:0]       mul_tag,
    input  wire [tomasulo_pkg::data_w-1:0]      mul_value,
    output logic                                busy,
    output logic                                cdb_valid,
    output logic [tomasulo_pkg::rob_w-1:0]      cdb_tag,
    output logic [tomasulo_pkg::data_w-1:0]     cdb_value
);

    logic                               res_valid;
    logic [tomasulo_pkg::rob_w-1:0]     res_tag;
    logic [tomasulo_pkg::data_w-1:0]    res_value;

    assign busy      = res_valid && mul_req;   // our result stays parked one more cycle
    assign cdb_valid = res_valid || mul_req;
    assign cdb_tag   = mul_req ? mul_tag : res_tag;
    assign cdb_value = mul_req ? mul_value : res_value;

    always_ff @(posedge clk1 or negedge rst_n)
    begin
        if (!rst_n)
            res_valid <= 1'b0;
        else if (disp_valid)
            res_valid <= 1'b1;
        else if (!mul_req)
            res_valid <= 1'b0;   // it went out on the bus this cycle
    end

    always_ff @(posedge clk1)
    begin
        if (disp_valid)
        begin
            res_tag <= disp_tag;
            case (disp_op)
                tomasulo_pkg::op_sub: res_value <= disp_a - disp_b;
                tomasulo_pkg::op_li:  res_value <= disp_b;   // immediate rides in b
                default:              res_value <= disp_a + disp_b;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/mul_exec.sv
`timescale 1ns/1ps
`default_nettype none

module mul_exec (
    input  wire                                 clk1,
    input  wire                                 rst_n,
    input  wire                                 disp_valid,
    input  wire tomasulo_pkg::opcode_t          disp_op,
    input  wire [tomasulo_pkg::data_w-1:0]      disp_a,
    input  wire [tomasulo_pkg::data_w-1:0]      disp_b,
    input  wire [tomasulo_pkg::rob_w-1:0]       disp_tag,
    output logic                                busy,
    output logic                                mul_req,
    output logic [tomasulo_pkg::rob_w-1:0]      mul_tag,
    output logic [tomasulo_pkg::data_w-1:0]     mul_value
);

    tomasulo_pkg::opcode_t              op_r;
    tomasulo_pkg::cycle_t               cnt;
    logic [tomasulo_pkg::data_w-1:0]    a_r;
    logic [tomasulo_pkg::data_w-1:0]    b_r;
    logic [tomasulo_pkg::data_w-1:0]    a_lo;
    logic [tomasulo_pkg::data_w-1:0]    b_lo;
    logic [tomasulo_pkg::data_w-1:0]    result;
    logic [tomasulo_pkg::rob_w-1:0]     tag_r;
    logic                               fire;

    assign fire = busy && cnt == 1;   // last counted cycle
    assign a_lo = {8'h00, a_r[7:0]};
    assign b_lo = {8'h00, b_r[7:0]};

    always_comb
    begin
        if (op_r == tomasulo_pkg::op_div)
            result = (b_r == '0) ? '1 : a_r / b_r;   // divide by zero saturates
        else
            result = a_lo * b_lo;
    end

    always_ff @(posedge clk1 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy    <= 1'b0;
            mul_req <= 1'b0;
            cnt     <= '0;
        end
        else
        begin
            mul_req <= fire;
            if (disp_valid)
            begin
                busy <= 1'b1;
                if (disp_op == tomasulo_pkg::op_div)
                    cnt <= tomasulo_pkg::cycle_t'(tomasulo_pkg::div_cycles - 1);
                else
                    cnt <= tomasulo_pkg::cycle_t'(tomasulo_pkg::mul_cycles - 1);
            end
            else if (busy)
            begin
                cnt <= cnt - 1;
                if (fire)
                    busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk1)
    begin
        if (disp_valid)
        begin
            op_r  <= disp_op;
            a_r   <= disp_a;
            b_r   <= disp_b;
            tag_r <= disp_tag;
        end
        if (fire)
        begin
            mul_tag   <= tag_r;
            mul_value <= result;
        end
    end

    // the station must hold off while an operation is in flight
    a_no_disp_busy: assert property (@(posedge clk1) disable iff (!rst_n)
        disp_valid |-> !busy);

endmodule

`default_nettype wire

//--- hdl/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  wire                                 clk1,
    input  wire                                 rst_n,
    input  wire                                 alloc,
    input  wire [tomasulo_pkg::reg_w-1:0]       alloc_rd,
    input  wire                                 cdb_valid,
    input  wire [tomasulo_pkg::rob_w-1:0]       cdb_tag,
    input  wire [tomasulo_pkg::data_w-1:0]      cdb_value,
    input  wire [tomasulo_pkg::rob_w-1:0]       query_a_tag,
    input  wire [tomasulo_pkg::rob_w-1:0]       query_b_tag,
    output logic                                full,
    output logic [tomasulo_pkg::rob_w-1:0]      alloc_tag,
    output logic                                query_a_ready,
    output logic [tomasulo_pkg::data_w-1:0]     query_a_value,
    output logic                                query_b_ready,
    output logic [tomasulo_pkg::data_w-1:0]     query_b_value,
    output logic                                commit_valid,
    output logic [tomasulo_pkg::reg_w-1:0]      commit_rd,
    output logic [tomasulo_pkg::data_w-1:0]     commit_value,
    output logic [tomasulo_pkg::rob_w-1:0]      commit_tag
);

    logic [tomasulo_pkg::rob_depth-1:0] busy;
    logic [tomasulo_pkg::rob_depth-1:0] ready;
    logic [tomasulo_pkg::reg_w-1:0]     rd_q    [tomasulo_pkg::rob_depth];
    logic [tomasulo_pkg::data_w-1:0]    value_q [tomasulo_pkg::rob_depth];
    logic [tomasulo_pkg::rob_w-1:0]     head;
    logic [tomasulo_pkg::rob_w-1:0]     tail;
    logic [tomasulo_pkg::rob_w:0]       count;

    assign full          = count == tomasulo_pkg::rob_depth;
    assign alloc_tag     = tail;
    assign query_a_ready = ready[query_a_tag];
    assign query_a_value = value_q[query_a_tag];
    assign query_b_ready = ready[query_b_tag];
    assign query_b_value = value_q[query_b_tag];
    assign commit_valid  = busy[head] && ready[head];
    assign commit_rd     = rd_q[head];
    assign commit_value  = value_q[head];
    assign commit_tag    = head;

    always_ff @(posedge clk1 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy  <= '0;
            ready <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end
        else
        begin
            if (cdb_valid)
                ready[cdb_tag] <= 1'b1;
            if (commit_valid)
            begin
                busy[head]  <= 1'b0;
                ready[head] <= 1'b0;
                head        <= head + 1;   // depth is a power of two so the pointer wraps
            end
            if (alloc)
            begin
                busy[tail]  <= 1'b1;
                ready[tail] <= 1'b0;
                tail        <= tail + 1;
            end
            if (alloc && !commit_valid)
                count <= count + 1;
            else if (!alloc && commit_valid)
                count <= count - 1;
        end
    end

    always_ff @(posedge clk1)
    begin
        if (alloc)
            rd_q[tail] <= alloc_rd;
        if (cdb_valid)
            value_q[cdb_tag] <= cdb_value;
    end

    // results are only ever broadcast for instructions still in flight
    a_cdb_tag_busy: assert property (@(posedge clk1) disable iff (!rst_n)
        cdb_valid |-> busy[cdb_tag] && !ready[cdb_tag]);

endmodule

`default_nettype wire

//--- hdl/register_status.sv
`timescale 1ns/1ps
`default_nettype none

module register_status (
    input  wire                                 clk1,
    input  wire                                 rst_n,
    input  wire                                 rename,
    input  wire [tomasulo_pkg::reg_w-1:0]       rename_rd,
    input  wire [tomasulo_pkg::rob_w-1:0]       rename_tag,
    input  wire [tomasulo_pkg::reg_w-1:0]       rs1,
    input  wire [tomasulo_pkg::reg_w-1:0]       rs2,
    input  wire                                 commit_valid,
    input  wire [tomasulo_pkg::reg_w-1:0]       commit_rd,
    input  wire [tomasulo_pkg::data_w-1:0]      commit_value,
    input  wire [tomasulo_pkg::rob_w-1:0]       commit_tag,
    output logic [tomasulo_pkg::data_w-1:0]     rs1_value,
    output logic                                rs1_busy,
    output logic [tomasulo_pkg::rob_w-1:0]      rs1_tag,
    output logic [tomasulo_pkg::data_w-1:0]     rs2_value,
    output logic                                rs2_busy,
    output logic [tomasulo_pkg::rob_w-1:0]      rs2_tag
);

    logic [tomasulo_pkg::data_w-1:0]    value_q [tomasulo_pkg::num_regs];
    logic [tomasulo_pkg::rob_w-1:0]     tag_q   [tomasulo_pkg::num_regs];
    logic [tomasulo_pkg::num_regs-1:0]  busy_q;

    assign rs1_value = value_q[rs1];
    assign rs1_busy  = busy_q[rs1];
    assign rs1_tag   = tag_q[rs1];
    assign rs2_value = value_q[rs2];
    assign rs2_busy  = busy_q[rs2];
    assign rs2_tag   = tag_q[rs2];

    always_ff @(posedge clk1 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy_q  <= '0;
            value_q <= '{default: '0};
        end
        else
        begin
            if (commit_valid)
            begin
                value_q[commit_rd] <= commit_value;
                if (tag_q[commit_rd] == commit_tag)
                    busy_q[commit_rd] <= 1'b0;   // a newer writer keeps the register renamed
            end
            if (rename)
                busy_q[rename_rd] <= 1'b1;
        end
    end

    always_ff @(posedge clk1)
    begin
        if (rename)
            tag_q[rename_rd] <= rename_tag;
    end

endmodule

`default_nettype wire

//--- hdl/tomasulo_core.sv
`timescale 1ns/1ps
`default_nettype none

module tomasulo_core (
    input  wire                                 clk1,
    input  wire                                 rst_n,
    input  wire                                 issue_valid,
    input  wire tomasulo_pkg::opcode_t          issue_op,
    input  wire [tomasulo_pkg::reg_w-1:0]       issue_rd,
    input  wire [tomasulo_pkg::reg_w-1:0]       issue_rs1,
    input  wire [tomasulo_pkg::reg_w-1:0]       issue_rs2,
    input  wire [tomasulo_pkg::data_w-1:0]      issue_imm,
    output logic                                issue_stall,
    output logic                                commit_valid,
    output logic [tomasulo_pkg::reg_w-1:0]      commit_rd,
    output logic [tomasulo_pkg::data_w-1:0]     commit_value
);

    logic                               issue_fire, to_mul, is_li;
    logic                               add_full, mul_full, rob_full;
    logic [tomasulo_pkg::rob_w-1:0]     rob_tag, commit_tag;
    logic [tomasulo_pkg::data_w-1:0]    rs1_value, rs2_value, qa_value, qb_value;
    logic                               rs1_busy, rs2_busy, qa_ready, qb_ready;
    logic [tomasulo_pkg::rob_w-1:0]     rs1_tag, rs2_tag;
    logic [tomasulo_pkg::data_w-1:0]    a_value, b_value;
    logic                               a_ready, b_ready;
    logic                               cdb_valid;
    logic [tomasulo_pkg::rob_w-1:0]     cdb_tag;
    logic [tomasulo_pkg::data_w-1:0]    cdb_value;
    logic                               add_disp, add_busy, mul_disp, mul_busy, mul_req;
    tomasulo_pkg::opcode_t              add_op, mul_op;
    logic [tomasulo_pkg::data_w-1:0]    add_a, add_b, mul_a, mul_b, mul_value;
    logic [tomasulo_pkg::rob_w-1:0]     add_tag, mul_tag, mul_res_tag;

    // a source is ready from the register file, then the ROB, then this cycle's CDB
    function automatic logic [tomasulo_pkg::data_w:0] pick(
        input logic                             busy,
        input logic [tomasulo_pkg::data_w-1:0]  reg_value,
        input logic [tomasulo_pkg::rob_w-1:0]   tag,
        input logic                             rob_ready,
        input logic [tomasulo_pkg::data_w-1:0]  rob_value,
        input logic                             bus_valid,
        input logic [tomasulo_pkg::rob_w-1:0]   bus_tag,
        input logic [tomasulo_pkg::data_w-1:0]  bus_value
    );
        if (!busy)
            return {1'b1, reg_value};
        if (rob_ready)
            return {1'b1, rob_value};
        if (bus_valid && bus_tag == tag)
            return {1'b1, bus_value};
        return {1'b0, reg_value};
    endfunction

    assign to_mul      = issue_op == tomasulo_pkg::op_mul || issue_op == tomasulo_pkg::op_div;
    assign is_li       = issue_op == tomasulo_pkg::op_li;
    assign issue_stall = rob_full || (to_mul ? mul_full : add_full);
    assign issue_fire  = issue_valid && !issue_stall;
    assign {a_ready, a_value} = is_li ? {1'b1, issue_imm} : pick(rs1_busy, rs1_value,
        rs1_tag, qa_ready, qa_value, cdb_valid, cdb_tag, cdb_value);
    assign {b_ready, b_value} = is_li ? {1'b1, issue_imm} : pick(rs2_busy, rs2_value,
        rs2_tag, qb_ready, qb_value, cdb_valid, cdb_tag, cdb_value);

    reservation_station u_add_rs (.clk1, .rst_n, .alloc(issue_fire && !to_mul),
        .alloc_op(issue_op), .alloc_tag(rob_tag), .a_value, .a_tag(rs1_tag), .a_ready,
        .b_value, .b_tag(rs2_tag), .b_ready, .unit_busy(add_busy), .cdb_valid, .cdb_tag,
        .cdb_value, .full(add_full), .disp_valid(add_disp), .disp_op(add_op),
        .disp_a(add_a), .disp_b(add_b), .disp_tag(add_tag));
    reservation_station u_mul_rs (.clk1, .rst_n, .alloc(issue_fire && to_mul),
        .alloc_op(issue_op), .alloc_tag(rob_tag), .a_value, .a_tag(rs1_tag), .a_ready,
        .b_value, .b_tag(rs2_tag), .b_ready, .unit_busy(mul_busy), .cdb_valid, .cdb_tag,
        .cdb_value, .full(mul_full), .disp_valid(mul_disp), .disp_op(mul_op),
        .disp_a(mul_a), .disp_b(mul_b), .disp_tag(mul_tag));
    add_exec u_add_exec (.clk1, .rst_n, .disp_valid(add_disp), .disp_op(add_op),
        .disp_a(add_a), .disp_b(add_b), .disp_tag(add_tag), .mul_req,
        .mul_tag(mul_res_tag), .mul_value, .busy(add_busy), .cdb_valid, .cdb_tag,
        .cdb_value);
    mul_exec u_mul_exec (.clk1, .rst_n, .disp_valid(mul_disp), .disp_op(mul_op),
        .disp_a(mul_a), .disp_b(mul_b), .disp_tag(mul_tag), .busy(mul_busy), .mul_req,
        .mul_tag(mul_res_tag), .mul_value);
    reorder_buffer u_rob (.clk1, .rst_n, .alloc(issue_fire), .alloc_rd(issue_rd),
        .cdb_valid, .cdb_tag, .cdb_value, .query_a_tag(rs1_tag), .query_b_tag(rs2_tag),
        .full(rob_full), .alloc_tag(rob_tag), .query_a_ready(qa_ready),
        .query_a_value(qa_value), .query_b_ready(qb_ready), .query_b_value(qb_value),
        .commit_valid, .commit_rd, .commit_value, .commit_tag);
    register_status u_regs (.clk1, .rst_n, .rename(issue_fire), .rename_rd(issue_rd),
        .rename_tag(rob_tag), .rs1(issue_rs1), .rs2(issue_rs2), .commit_valid, .commit_rd,
        .commit_value, .commit_tag, .rs1_value, .rs1_busy, .rs1_tag, .rs2_value, .rs2_busy,
        .rs2_tag);

endmodule

`default_nettype wire

//--- test/tb_tomasulo_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tomasulo_core;

    localparam int timeout_cycles = 200;

    logic                               clk1 = 1'b0;
    logic                               rst_n;
    logic                               issue_valid;
    tomasulo_pkg::opcode_t              issue_op;
    logic [tomasulo_pkg::reg_w-1:0]     issue_rd;
    logic [tomasulo_pkg::reg_w-1:0]     issue_rs1;
    logic [tomasulo_pkg::reg_w-1:0]     issue_rs2;
    logic [tomasulo_pkg::data_w-1:0]    issue_imm;
    logic                               issue_stall;
    logic                               commit_valid;
    logic [tomasulo_pkg::reg_w-1:0]     commit_rd;
    logic [tomasulo_pkg::data_w-1:0]    commit_value;

    logic [15:0]    testdata [0:255];   // count, instructions, count, commit pairs
    int             num_instr;
    int             num_commits;
    bit             stall_seen;

    tomasulo_core u_tomasulo_core (.clk1, .rst_n, .issue_valid, .issue_op, .issue_rd,
        .issue_rs1, .issue_rs2, .issue_imm, .issue_stall, .commit_valid, .commit_rd,
        .commit_value);

    always #2 clk1 = ~clk1;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped after the first error");
    endtask

    task automatic check_value(input logic [15:0] actual, input logic [15:0] expected,
        input string what);
        if (actual !== expected)
        begin
            stop_with_failure($sformatf("FAIL at %0t ns: %s is %h, expected %h", $time, what,
                actual, expected));
        end
    endtask

    // drives one instruction and returns once it will be taken on the next rising edge
    task automatic issue_instr(input int idx);
        int base;
        int wait_cycles;
        base        = 1 + idx * 5;
        wait_cycles = 0;
        @(posedge clk1);
        issue_valid <= 1'b1;
        issue_op    <= tomasulo_pkg::opcode_t'(testdata[base][tomasulo_pkg::opcode_w-1:0]);
        issue_rd    <= testdata[base+1][tomasulo_pkg::reg_w-1:0];
        issue_rs1   <= testdata[base+2][tomasulo_pkg::reg_w-1:0];
        issue_rs2   <= testdata[base+3][tomasulo_pkg::reg_w-1:0];
        issue_imm   <= testdata[base+4];
        @(negedge clk1);
        while (issue_stall && wait_cycles < timeout_cycles)
        begin
            stall_seen = 1'b1;
            wait_cycles++;
            @(negedge clk1);
        end
        if (issue_stall)
            stop_with_failure($sformatf("instruction %0d was never accepted", idx));
    endtask

    task automatic drive_program();
        int idle;
        for (int i = 0; i < num_instr; i++)
        begin
            idle = int'($urandom % 2);
            repeat (idle)
            begin
                @(posedge clk1);
                issue_valid <= 1'b0;
            end
            issue_instr(i);
        end
        @(posedge clk1);
        issue_valid <= 1'b0;   // last instruction is taken on this edge
    endtask

    task automatic wait_for_commit(input int k);
        int wait_cycles;
        wait_cycles = 0;
        @(negedge clk1);
        while (!commit_valid && wait_cycles < timeout_cycles)
        begin
            wait_cycles++;
            @(negedge clk1);
        end
        if (!commit_valid)
            stop_with_failure($sformatf("commit %0d did not arrive in time", k));
    endtask

    // commits must come in program order, so the file order is the expected order
    task automatic check_commits();
        int pos;
        for (int k = 0; k < num_commits; k++)
        begin
            pos = 2 + num_instr * 5 + k * 2;
            wait_for_commit(k);
            check_value(16'(commit_rd), testdata[pos], $sformatf("commit %0d rd", k));
            check_value(commit_value, testdata[pos+1], $sformatf("commit %0d value", k));
        end
    endtask

    initial
    begin
        int unsigned seed;
        seed = 25;
        void'($urandom(seed));
        rst_n        = 1'b0;
        issue_valid  = 1'b0;
        issue_op     = tomasulo_pkg::op_add;
        issue_rd     = '0;
        issue_rs1    = '0;
        issue_rs2    = '0;
        issue_imm    = '0;
        stall_seen   = 1'b0;
        $readmemh("test/tomasulo_testdata.txt", testdata);
        num_instr   = int'(testdata[0]);
        num_commits = int'(testdata[1 + num_instr * 5]);
        repeat (3) @(posedge clk1);
        rst_n <= 1'b1;
        @(negedge clk1);
        check_value(16'(commit_valid), 16'd0, "commit_valid after reset");
        check_value(16'(issue_stall), 16'd0, "issue_stall after reset");
        fork
            drive_program();
            check_commits();
        join
        repeat (10)
        begin
            @(negedge clk1);
            check_value(16'(commit_valid), 16'd0, "commit_valid after the last commit");
        end
        check_value(16'(stall_seen), 16'd1, "issue_stall during the mul burst");
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/tomasulo_testdata.txt
// word 0 is the instruction count, then one line per instruction: op rd rs1 rs2 imm
// then the commit count, then expected commits as rd value pairs in program order
// op codes: 0 add, 1 sub, 2 mul, 3 div, 4 li
0018
// li, then an add reading both results
4 1 0 0 0012
4 2 0 0 0034
0 3 1 2 0000
// mul feeds add feeds div
4 4 0 0 0105
2 5 4 2 0000
0 6 5 3 0000
3 7 6 1 0000
// slow div ahead of an independent add
3 8 6 2 0000
0 9 1 1 0000
// two writes to r10, then a reader
2 a 4 4 0000
4 a 0 0 2222
0 b a 1 0000
// div chain holds back a burst of muls until the station fills
4 f 0 0 0003
3 d 6 1 0000
3 e d f 0000
2 c e 2 0000
2 0 e f 0000
2 5 e e 0000
2 7 e 1 0000
2 8 4 9 0000
// divide by zero, sub below zero, late read of r10
4 3 0 0 0000
3 9 4 3 0000
1 b 3 1 0000
0 c a f 0000
0018
1 0012  2 0034  3 0046  4 0105
5 0104  6 014a  7 0012  8 0006
9 0024  a 0019  a 2222  b 2234
f 0003  d 0012  e 0006  c 0138
0 0012  5 0024  7 006c  8 00b4
3 0000  9 ffff  b ffee  c 2225

//--- tomasulo_core.f
hdl/tomasulo_pkg.sv
hdl/reservation_station.sv
hdl/add_exec.sv
hdl/mul_exec.sv
hdl/reorder_buffer.sv
hdl/register_status.sv
hdl/tomasulo_core.sv
test/tb_tomasulo_core.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_tomasulo_core
RTL_TOP    ?= tomasulo_core
FILELIST   ?= tomasulo_core.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

FAIL_MSG = Simulation finished: FAIL
PASS_MSG = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no result found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
